// File: verilog/valu_cfg.svh
`ifndef VALU_CFG_SVH
`define VALU_CFG_SVH

// number of identical lanes in one request
`define VALU_LANES 2

// width of one lane in bits, also the widest element
`define VALU_XLEN 32

// register stages between request acceptance and response
// controller and lanes are both built around this depth
`define VALU_STAGES 4

`endif

// File: verilog/valu_pkg.sv
`include "valu_cfg.svh"

package valu_pkg;

   // operation codes, grouped by datapath: logic/add, multiply, compare
   typedef enum logic [4:0] {
      OP_ADD   = 5'h00,
      OP_SUB   = 5'h01,
      OP_AND   = 5'h02,
      OP_OR    = 5'h03,
      OP_XOR   = 5'h04,
      OP_MUL   = 5'h08,     // low half of product
      OP_MULH  = 5'h09,     // high half, signed x signed
      OP_MULHU = 5'h0a,     // high half, unsigned x unsigned
      OP_MACC  = 5'h0b,     // low half of op1*op2+op3
      OP_SLT   = 5'h10,
      OP_SLTU  = 5'h11,
      OP_SLE   = 5'h12,
      OP_SLEU  = 5'h13,
      OP_SGT   = 5'h14,
      OP_SGTU  = 5'h15,
      OP_SEQ   = 5'h16,
      OP_SNE   = 5'h17
   } alu_op_e;

   // element width, 2'b11 is not a legal value
   typedef enum logic [1:0] {
      SEW8  = 2'b00,
      SEW16 = 2'b01,
      SEW32 = 2'b10
   } sew_e;

   typedef struct packed {
      alu_op_e                              op;
      logic [`VALU_LANES*`VALU_XLEN-1:0]    op1;   // lane l in bits [l*XLEN +: XLEN]
      logic [`VALU_LANES*`VALU_XLEN-1:0]    op2;
      logic [`VALU_LANES*`VALU_XLEN-1:0]    op3;   // accumulate term, macc only
   } alu_req_t;

   typedef struct packed {
      logic [`VALU_LANES*`VALU_XLEN-1:0]    result;  // zero above SEW in every lane
      sew_e                                 sew;     // width this item was computed with
   } alu_rsp_t;

   // stage control shared by all lanes
   typedef struct packed {
      logic [`VALU_STAGES-1:0]              en;    // en[i] loads stage register i
      sew_e [`VALU_STAGES-1:0]              sew;   // SEW of the item held in stage i
   } lane_ctl_t;

endpackage

// File: verilog/valu_csr.sv
module valu_csr (
   input  logic            clk,
   input  logic            rstn,
   input  logic            cfg_valid_i,
   input  valu_pkg::sew_e  cfg_sew_i,
   input  logic            pipe_empty_i,   // no item in any stage
   input  logic            req_valid_i,
   output logic            cfg_ready_o,
   output valu_pkg::sew_e  sew_o
);

   valu_pkg::sew_e sew_q;   // current element width
   logic           cfg_write;
   logic           sew_legal;

   // grant only with nothing in flight and no request waiting,
   // so a width change never splits an item or races an accept
   assign cfg_ready_o = pipe_empty_i & ~req_valid_i;

   assign cfg_write = cfg_valid_i & cfg_ready_o;

   // 2'b11 has no width, such a write completes but is dropped
   assign sew_legal = cfg_sew_i inside {valu_pkg::SEW8, valu_pkg::SEW16, valu_pkg::SEW32};

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         sew_q <= valu_pkg::SEW32;   // full width out of reset
      end
      else if (cfg_write && sew_legal)
      begin
         sew_q <= cfg_sew_i;         // visible from the next cycle on
      end
   end

   assign sew_o = sew_q;   // read-back and source for the controller

endmodule

// File: verilog/valu_pipe_ctrl.sv
`include "valu_cfg.svh"

module valu_pipe_ctrl (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 req_valid_i,
   input  logic                 rsp_ready_i,
   input  valu_pkg::sew_e       sew_i,        // width from the CSR, sampled on accept
   output logic                 req_ready_o,
   output logic                 rsp_valid_o,
   output logic                 pipe_empty_o,
   output valu_pkg::lane_ctl_t  lane_ctl_o
);

   localparam int S = `VALU_STAGES;

   logic [S-1:0]           vld_q;      // one valid bit per stage register
   valu_pkg::sew_e [S-1:0] sew_q;      // per-item width travels with the valid bit
   logic [S-1:0]           stage_en;
   logic                   advance;

   // everything moves together, a bubble in the last stage frees the whole chain
   assign advance = ~vld_q[S-1] | rsp_ready_i;

   // ready does not look at req_valid_i
   assign req_ready_o = advance;

   // a stage only loads when something real arrives from the left
   always_comb
   begin
      stage_en[0] = req_valid_i & advance;   // accept edge
      for (int i = 1; i < S; i++)
      begin
         stage_en[i] = vld_q[i-1] & advance;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_q <= '0;
      end
      else if (advance)
      begin
         vld_q <= {vld_q[S-2:0], req_valid_i};   // stall holds every bit
      end
   end

   always_ff @(posedge clk)
   begin
      if (stage_en[0])
      begin
         sew_q[0] <= sew_i;
      end
      for (int i = 1; i < S; i++)
      begin
         if (stage_en[i])
         begin
            sew_q[i] <= sew_q[i-1];
         end
      end
   end

   // an item accepted at edge k sits in the last stage after edge k+3
   // and leaves on the handshake at edge k+4 when rsp_ready_i is high
   assign rsp_valid_o  = vld_q[S-1];
   assign pipe_empty_o = ~|vld_q;

   assign lane_ctl_o.en  = stage_en;
   assign lane_ctl_o.sew = sew_q;

endmodule

// File: verilog/valu_lane.sv
`include "valu_cfg.svh"

module valu_lane (
   input  logic                   clk,
   input  logic                   rstn,
   input  valu_pkg::lane_ctl_t    lane_ctl_i,
   input  valu_pkg::alu_op_e      op_i,      // stage 1 opcode, one copy held in top
   input  logic [`VALU_XLEN-1:0]  op1_i,
   input  logic [`VALU_XLEN-1:0]  op2_i,
   input  logic [`VALU_XLEN-1:0]  op3_i,
   output logic [`VALU_XLEN-1:0]  result_o
);

   localparam int XLEN = `VALU_XLEN;

   // stage 1
   logic [XLEN-1:0]          op1_s1;
   logic [XLEN-1:0]          op2_s1;
   logic [XLEN-1:0]          op3_s1;
   logic signed [XLEN:0]     a_x;         // extended from SEW, one guard bit
   logic signed [XLEN:0]     b_x;
   logic signed [2*XLEN+1:0] prod_full;
   logic [XLEN-1:0]          alu_res;
   logic                     cmp_next;
   // stage 2
   valu_pkg::alu_op_e        op_s2;
   logic [2*XLEN-1:0]        res_s2;      // full product or zero-extended alu result
   logic [XLEN-1:0]          op3_s2;
   logic                     cmp_s2;
   // stage 3
   valu_pkg::alu_op_e        op_s3;
   logic [2*XLEN-1:0]        acc_s3;
   logic                     cmp_s3;
   logic [XLEN-1:0]          sel;
   logic [XLEN-1:0]          fmt;
   // stage 4
   logic [XLEN-1:0]          result_q;

   function automatic logic is_signed(input valu_pkg::alu_op_e op);
      return op inside {valu_pkg::OP_MULH, valu_pkg::OP_SLT, valu_pkg::OP_SLE,
                        valu_pkg::OP_SGT};
   endfunction

   function automatic logic is_mul(input valu_pkg::alu_op_e op);
      return op inside {valu_pkg::OP_MUL, valu_pkg::OP_MULH, valu_pkg::OP_MULHU,
                        valu_pkg::OP_MACC};
   endfunction

   function automatic logic is_cmp(input valu_pkg::alu_op_e op);
      return op inside {valu_pkg::OP_SLT, valu_pkg::OP_SLTU, valu_pkg::OP_SLE,
                        valu_pkg::OP_SLEU, valu_pkg::OP_SGT, valu_pkg::OP_SGTU,
                        valu_pkg::OP_SEQ, valu_pkg::OP_SNE};
   endfunction

   // unsigned ops get a zero guard bit, so one signed datapath serves both
   function automatic logic [XLEN:0] ext_op(input logic [XLEN-1:0] v,
                                            input valu_pkg::sew_e sew,
                                            input logic sgn);
      logic [XLEN:0] r;
      case (sew)
         valu_pkg::SEW8:  r = {{(XLEN-7){sgn & v[7]}}, v[7:0]};
         valu_pkg::SEW16: r = {{(XLEN-15){sgn & v[15]}}, v[15:0]};
         default:         r = {sgn & v[XLEN-1], v};
      endcase
      return r;
   endfunction

   always_ff @(posedge clk)
   begin
      if (lane_ctl_i.en[0])
      begin
         op1_s1 <= op1_i;
         op2_s1 <= op2_i;
         op3_s1 <= op3_i;
      end
   end

   assign a_x = ext_op(op1_s1, lane_ctl_i.sew[0], is_signed(op_i));
   assign b_x = ext_op(op2_s1, lane_ctl_i.sew[0], is_signed(op_i));

   assign prod_full = a_x * b_x;   // 33x33 signed, low 64 bits exact for both signs

   // bits above SEW are don't care here and cleared in stage 4
   always_comb
   begin
      case (op_i)
         valu_pkg::OP_SUB: alu_res = op1_s1 - op2_s1;
         valu_pkg::OP_AND: alu_res = op1_s1 & op2_s1;
         valu_pkg::OP_OR:  alu_res = op1_s1 | op2_s1;
         valu_pkg::OP_XOR: alu_res = op1_s1 ^ op2_s1;
         default:          alu_res = op1_s1 + op2_s1;
      endcase
   end

   always_comb
   begin
      case (op_i)
         valu_pkg::OP_SLT, valu_pkg::OP_SLTU: cmp_next = a_x < b_x;
         valu_pkg::OP_SLE, valu_pkg::OP_SLEU: cmp_next = a_x <= b_x;
         valu_pkg::OP_SGT, valu_pkg::OP_SGTU: cmp_next = a_x > b_x;
         valu_pkg::OP_SEQ:                    cmp_next = a_x == b_x;
         valu_pkg::OP_SNE:                    cmp_next = a_x != b_x;
         default:                             cmp_next = 1'b0;
      endcase
   end

   // opcode pipeline, stages 2 and 3
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         op_s2 <= valu_pkg::OP_ADD;
         op_s3 <= valu_pkg::OP_ADD;
      end
      else
      begin
         if (lane_ctl_i.en[1])
            op_s2 <= op_i;
         if (lane_ctl_i.en[2])
            op_s3 <= op_s2;
      end
   end

   always_ff @(posedge clk)
   begin
      if (lane_ctl_i.en[1])
      begin
         res_s2 <= is_mul(op_i) ? prod_full[2*XLEN-1:0] : {{XLEN{1'b0}}, alu_res};
         op3_s2 <= op3_s1;   // accumulate term lags one stage behind the product
         cmp_s2 <= cmp_next;
      end
   end

   always_ff @(posedge clk)
   begin
      if (lane_ctl_i.en[2])
      begin
         if (op_s2 == valu_pkg::OP_MACC)
            acc_s3 <= res_s2 + {{XLEN{1'b0}}, op3_s2};   // only low SEW bits survive
         else
            acc_s3 <= res_s2;
         cmp_s3 <= cmp_s2;
      end
   end

   // stage 4 format, width of the item now in stage 3
   always_comb
   begin
      sel = acc_s3[XLEN-1:0];
      if (is_cmp(op_s3))
      begin
         sel = {{(XLEN-1){1'b0}}, cmp_s3};
      end
      else if (op_s3 == valu_pkg::OP_MULH || op_s3 == valu_pkg::OP_MULHU)
      begin
         case (lane_ctl_i.sew[2])
            valu_pkg::SEW8:  sel = {{(XLEN-8){1'b0}}, acc_s3[15:8]};
            valu_pkg::SEW16: sel = {{(XLEN-16){1'b0}}, acc_s3[31:16]};
            default:         sel = acc_s3[2*XLEN-1:XLEN];
         endcase
      end
      case (lane_ctl_i.sew[2])
         valu_pkg::SEW8:  fmt = {{(XLEN-8){1'b0}}, sel[7:0]};
         valu_pkg::SEW16: fmt = {{(XLEN-16){1'b0}}, sel[15:0]};
         default:         fmt = sel;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (lane_ctl_i.en[3])
         result_q <= fmt;   // held under back-pressure
   end

   assign result_o = result_q;

endmodule

// File: verilog/valu_top.sv
`include "valu_cfg.svh"

module valu_top (
   input  logic                clk,
   input  logic                rstn,
   // request channel
   input  logic                req_valid_i,
   output logic                req_ready_o,
   input  valu_pkg::alu_req_t  req_i,
   // response channel
   output logic                rsp_valid_o,
   input  logic                rsp_ready_i,
   output valu_pkg::alu_rsp_t  rsp_o,
   // configuration channel
   input  logic                cfg_valid_i,
   output logic                cfg_ready_o,
   input  valu_pkg::sew_e      cfg_sew_i,
   output valu_pkg::sew_e      sew_o
);

   localparam int XLEN = `VALU_XLEN;

   valu_pkg::lane_ctl_t                    lane_ctl;
   logic                                   pipe_empty;
   valu_pkg::alu_op_e                      op_q;       // stage 1 opcode, shared by all lanes
   logic [`VALU_LANES-1:0][XLEN-1:0]       lane_res;

   valu_csr u_csr (
      .clk          (clk),
      .rstn         (rstn),
      .cfg_valid_i  (cfg_valid_i),
      .cfg_sew_i    (cfg_sew_i),
      .pipe_empty_i (pipe_empty),
      .req_valid_i  (req_valid_i),
      .cfg_ready_o  (cfg_ready_o),
      .sew_o        (sew_o)
   );

   valu_pipe_ctrl u_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid_i  (req_valid_i),
      .rsp_ready_i  (rsp_ready_i),
      .sew_i        (sew_o),
      .req_ready_o  (req_ready_o),
      .rsp_valid_o  (rsp_valid_o),
      .pipe_empty_o (pipe_empty),
      .lane_ctl_o   (lane_ctl)
   );

   // one opcode register per item instead of one per lane
   always_ff @(posedge clk)
   begin
      if (!rstn)
         op_q <= valu_pkg::OP_ADD;
      else if (lane_ctl.en[0])
         op_q <= req_i.op;
   end

   for (genvar l = 0; l < `VALU_LANES; l++)
   begin : g_lane
      valu_lane u_lane (
         .clk        (clk),
         .rstn       (rstn),
         .lane_ctl_i (lane_ctl),
         .op_i       (op_q),
         .op1_i      (req_i.op1[l*XLEN +: XLEN]),
         .op2_i      (req_i.op2[l*XLEN +: XLEN]),
         .op3_i      (req_i.op3[l*XLEN +: XLEN]),
         .result_o   (lane_res[l])
      );
   end

   // width tag comes from the last stage, same item as the lane results
   assign rsp_o = '{result: lane_res, sew: lane_ctl.sew[`VALU_STAGES-1]};

endmodule

// File: verification/valu_assertions.sv
`include "valu_cfg.svh"

module valu_assertions (
   input logic                clk,
   input logic                rstn,
   input logic                req_valid_i,
   input logic                req_ready_o,
   input valu_pkg::alu_req_t  req_i,
   input logic                rsp_valid_o,
   input logic                rsp_ready_i,
   input valu_pkg::alu_rsp_t  rsp_o,
   input logic                cfg_valid_i,
   input logic                cfg_ready_o,
   input valu_pkg::sew_e      cfg_sew_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // read by the testbench at the end of the run

   // a stalled sender keeps valid and payload until the transfer
   req_hold: assert property (@(posedge clk) disable iff (!rstn)
         req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
      else
      begin
         $error("request valid or payload changed before the handshake");
         fail_cnt++;
      end

   rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
         rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
      else
      begin
         $error("response valid or payload changed under back-pressure");
         fail_cnt++;
      end

   cfg_hold: assert property (@(posedge clk) disable iff (!rstn)
         cfg_valid_i && !cfg_ready_o |=> cfg_valid_i && $stable(cfg_sew_i))
      else
      begin
         $error("configuration write changed before the handshake");
         fail_cnt++;
      end

   // first edge out of reset sees an empty pipeline
   rsp_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !rsp_valid_o)
      else
      begin
         $error("response valid high right after reset");
         fail_cnt++;
      end

   // grant needs an idle request channel and no item waiting at the output
   cfg_excl: assert property (@(posedge clk) disable iff (!rstn)
         cfg_ready_o |-> !req_valid_i && !rsp_valid_o)
      else
      begin
         $error("configuration ready while a request is pending or the pipeline is busy");
         fail_cnt++;
      end

endmodule

// File: verification/valu_tb.sv
`include "valu_cfg.svh"

module valu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LANES      = `VALU_LANES;
   localparam int XLEN       = `VALU_XLEN;
   localparam int RW         = LANES * XLEN;
   localparam int RST_CYCLES = 8;
   localparam int N_REQ      = 40 + 48 + 72 + 16 + 60 + 24;   // requests over all tests

   typedef struct packed {
      valu_pkg::alu_rsp_t rsp;       // expected response
      valu_pkg::alu_op_e  op;
      logic [31:0]        acc_cyc;   // cycle of the accept edge
   } exp_item_t;

   logic               clk;
   logic               rstn;
   logic               req_valid_i;
   logic               req_ready_o;
   valu_pkg::alu_req_t req_i;
   logic               rsp_valid_o;
   logic               rsp_ready_i;
   valu_pkg::alu_rsp_t rsp_o;
   logic               cfg_valid_i;
   logic               cfg_ready_o;
   valu_pkg::sew_e     cfg_sew_i;
   valu_pkg::sew_e     sew_o;

   logic [31:0]        lfsr_q = 32'h8bc67492;
   exp_item_t          exp_q [$];              // accepted, not yet answered
   valu_pkg::sew_e     cur_sew = valu_pkg::SEW32;   // model of the width register
   int                 cyc;
   int                 req_cnt;
   int                 rsp_cnt;
   int                 chk_cnt;
   int                 err_cnt;
   int                 test_chk0;
   int                 test_err0;
   int                 n_tests;
   int                 last_rsp_cyc;
   string              test_name;
   bit                 bp_mode;                // random rsp_ready_i
   bit                 lat_mode;               // check latency and spacing
   bit                 lat_seen;

   valu_pkg::sew_e     sew_list [3] = '{valu_pkg::SEW8, valu_pkg::SEW16, valu_pkg::SEW32};
   valu_pkg::alu_op_e  op_list [17] = '{valu_pkg::OP_ADD, valu_pkg::OP_SUB, valu_pkg::OP_AND,
      valu_pkg::OP_OR, valu_pkg::OP_XOR, valu_pkg::OP_MUL, valu_pkg::OP_MULH,
      valu_pkg::OP_MULHU, valu_pkg::OP_MACC, valu_pkg::OP_SLT, valu_pkg::OP_SLTU,
      valu_pkg::OP_SLE, valu_pkg::OP_SLEU, valu_pkg::OP_SGT, valu_pkg::OP_SGTU,
      valu_pkg::OP_SEQ, valu_pkg::OP_SNE};   // 0-4 logic, 5-8 multiply, 9-16 compare

   valu_top dut_i (.*);

   bind valu_top valu_assertions u_assert (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   always @(negedge clk)
      cyc <= cyc + 1;   // read on rising edges only

   // galois form, taps 32 22 2 1
   function automatic logic lfsr_step();
      logic lsb;
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb)
         lfsr_q = lfsr_q ^ 32'h80200003;
      return lsb;
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_step()};   // one step per bit
      return v;
   endfunction

   function automatic int sew_bits(input valu_pkg::sew_e s);
      return (s == valu_pkg::SEW8) ? 8 : (s == valu_pkg::SEW16) ? 16 : 32;
   endfunction

   function automatic logic [XLEN-1:0] ref_alu(input valu_pkg::alu_op_e op,
                                               input valu_pkg::sew_e sew,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b,
                                               input logic [XLEN-1:0] c);
      int unsigned        w;
      logic [63:0]        mask;
      logic [63:0]        sbit;
      logic [63:0]        ua;
      logic [63:0]        ub;
      logic [63:0]        uc;
      logic signed [63:0] sa;
      logic signed [63:0] sb;
      logic signed [63:0] sp;
      logic [63:0]        r;
      w    = sew_bits(sew);
      mask = (64'd1 << w) - 64'd1;
      sbit = 64'd1 << (w - 1);
      ua   = {32'd0, a} & mask;   // only the low SEW bits count
      ub   = {32'd0, b} & mask;
      uc   = {32'd0, c} & mask;
      sa   = (ua ^ sbit) - sbit;  // flip and subtract gives the signed value
      sb   = (ub ^ sbit) - sbit;
      sp   = sa * sb;             // fits in 64 bits for any SEW
      case (op)
         valu_pkg::OP_ADD:   r = ua + ub;
         valu_pkg::OP_SUB:   r = ua - ub;
         valu_pkg::OP_AND:   r = ua & ub;
         valu_pkg::OP_OR:    r = ua | ub;
         valu_pkg::OP_XOR:   r = ua ^ ub;
         valu_pkg::OP_MUL:   r = ua * ub;
         valu_pkg::OP_MULH:  r = sp >> w;
         valu_pkg::OP_MULHU: r = (ua * ub) >> w;
         valu_pkg::OP_MACC:  r = ua * ub + uc;
         valu_pkg::OP_SLT:   r = (sa < sb) ? 64'd1 : 64'd0;
         valu_pkg::OP_SLTU:  r = (ua < ub) ? 64'd1 : 64'd0;
         valu_pkg::OP_SLE:   r = (sa <= sb) ? 64'd1 : 64'd0;
         valu_pkg::OP_SLEU:  r = (ua <= ub) ? 64'd1 : 64'd0;
         valu_pkg::OP_SGT:   r = (sa > sb) ? 64'd1 : 64'd0;
         valu_pkg::OP_SGTU:  r = (ua > ub) ? 64'd1 : 64'd0;
         valu_pkg::OP_SEQ:   r = (ua == ub) ? 64'd1 : 64'd0;
         valu_pkg::OP_SNE:   r = (ua != ub) ? 64'd1 : 64'd0;
         default:            r = '0;
      endcase
      return r[XLEN-1:0] & mask[XLEN-1:0];   // zero above SEW
   endfunction

   // edgy draws sign bits at the SEW boundary and equal operands half the time
   function automatic valu_pkg::alu_req_t make_req(input valu_pkg::alu_op_e op,
                                                   input logic edgy);
      valu_pkg::alu_req_t r;
      int                 w;
      w    = sew_bits(cur_sew);
      r.op = op;
      for (int l = 0; l < LANES; l++)
      begin
         r.op1[l*XLEN +: XLEN] = draw_bits(32);
         r.op2[l*XLEN +: XLEN] = draw_bits(32);
         r.op3[l*XLEN +: XLEN] = draw_bits(32);
         if (edgy)
         begin
            r.op1[l*XLEN + w - 1] = lfsr_step();
            if (lfsr_step())
               r.op2[l*XLEN +: XLEN] = r.op1[l*XLEN +: XLEN];
            else
               r.op2[l*XLEN + w - 1] = lfsr_step();
         end
      end
      return r;
   endfunction

   task automatic expect_equal(input string what, input logic [RW-1:0] exp,
                               input logic [RW-1:0] act);
      chk_cnt++;
      assert (exp === act)
      else
      begin
         $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic require(input logic ok, input string msg);
      chk_cnt++;
      assert (ok)
      else
      begin
         $display("%s went wrong: %s", test_name, msg);
         err_cnt++;
      end
   endtask

   task automatic tick();
      @(negedge clk);
      rsp_ready_i = bp_mode ? lfsr_step() : 1'b1;   // consumer side, one driver
   endtask

   task automatic send_req(input valu_pkg::alu_req_t r);
      logic taken;
      req_i       = r;
      req_valid_i = 1'b1;
      taken       = 1'b0;
      while (!taken)
      begin
         @(posedge clk);
         taken = req_ready_o;   // pre-edge value decides the transfer
         tick();
      end
      req_valid_i = 1'b0;
   endtask

   task automatic write_cfg(input valu_pkg::sew_e s);
      logic taken;
      int   pending;
      cfg_sew_i   = s;
      cfg_valid_i = 1'b1;
      taken       = 1'b0;
      while (!taken)
      begin
         @(posedge clk);
         taken   = cfg_ready_o;
         pending = req_cnt - rsp_cnt;   // items still inside at the write edge
         tick();
      end
      cfg_valid_i = 1'b0;
      require(pending == 0, "configuration write accepted with items in flight");
      expect_equal("sew read-back", s, sew_o);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_chk0 = chk_cnt;
      test_err0 = err_cnt;
   endtask

   task automatic end_test();
      while (exp_q.size() != 0)
         tick();   // drain, watchdog covers a hang
      expect_equal("response count", req_cnt, rsp_cnt);
      n_tests++;
      $display("test %-12s %0d checks, %0d errors", test_name, chk_cnt - test_chk0,
               err_cnt - test_err0);
   endtask

   // expected values are fixed at the accept edge with the width valid then
   always @(posedge clk)
   begin : track_req
      exp_item_t e;
      if (!rstn)
         cur_sew = valu_pkg::SEW32;
      else if (cfg_valid_i && cfg_ready_o)
         cur_sew = cfg_sew_i;   // never on the same edge as an accept
      if (rstn && req_valid_i && req_ready_o)
      begin
         e.op      = req_i.op;
         e.acc_cyc = cyc;
         e.rsp.sew = cur_sew;
         for (int l = 0; l < LANES; l++)
            e.rsp.result[l*XLEN +: XLEN] = ref_alu(req_i.op, cur_sew,
               req_i.op1[l*XLEN +: XLEN], req_i.op2[l*XLEN +: XLEN],
               req_i.op3[l*XLEN +: XLEN]);
         exp_q.push_back(e);
         req_cnt <= req_cnt + 1;
      end
   end

   always @(posedge clk)
   begin : compare_rsp
      exp_item_t e;
      if (rstn && rsp_valid_o && rsp_ready_i)
      begin
         rsp_cnt <= rsp_cnt + 1;
         if (exp_q.size() == 0)
            require(1'b0, "response arrived with no request outstanding");
         else
         begin
            e = exp_q.pop_front();
            expect_equal("result", e.rsp.result, rsp_o.result);
            expect_equal("sew", e.rsp.sew, rsp_o.sew);
            if (e.op inside {valu_pkg::OP_SLT, valu_pkg::OP_SLTU, valu_pkg::OP_SLE,
                             valu_pkg::OP_SLEU, valu_pkg::OP_SGT, valu_pkg::OP_SGTU,
                             valu_pkg::OP_SEQ, valu_pkg::OP_SNE})
               for (int l = 0; l < LANES; l++)
                  require(rsp_o.result[l*XLEN +: XLEN] <= 1, "comparison not 0 or 1");
            if (lat_mode)
            begin
               expect_equal("latency", `VALU_STAGES, cyc - e.acc_cyc);
               if (lat_seen)
                  expect_equal("response spacing", 1, cyc - last_rsp_cyc);
               last_rsp_cyc = cyc;
               lat_seen     = 1'b1;
            end
         end
      end
   end

   initial
   begin
      repeat (RST_CYCLES + N_REQ * 20) @(posedge clk);
      $display("watchdog: tests did not finish within %0d cycles",
               RST_CYCLES + N_REQ * 20);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      int total;
      rstn        = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      rsp_ready_i = 1'b1;
      cfg_valid_i = 1'b0;
      cfg_sew_i   = valu_pkg::SEW32;
      repeat (RST_CYCLES) @(negedge clk);
      rstn = 1'b1;
      tick();

      start_test("arith");   // reset width is SEW32
      for (int i = 0; i < 40; i++)
         send_req(make_req(op_list[i % 5], 1'b0));
      end_test();

      start_test("multiply");
      for (int s = 0; s < 3; s++)
      begin
         write_cfg(sew_list[s]);
         for (int o = 5; o < 9; o++)
            repeat (4) send_req(make_req(op_list[o], 1'b0));
      end
      end_test();

      start_test("compare");
      for (int s = 0; s < 3; s++)
      begin
         write_cfg(sew_list[s]);
         for (int o = 9; o < 17; o++)
            repeat (3) send_req(make_req(op_list[o], 1'b1));
      end
      end_test();

      start_test("latency");   // back-to-back with rsp_ready_i high
      lat_mode = 1'b1;
      lat_seen = 1'b0;
      for (int i = 0; i < 16; i++)
         send_req(make_req(op_list[draw_bits(5) % 17], 1'b0));
      end_test();
      lat_mode = 1'b0;

      start_test("backpressure");
      bp_mode = 1'b1;
      for (int i = 0; i < 60; i++)
      begin
         send_req(make_req(op_list[draw_bits(5) % 17], lfsr_step()));
         repeat (draw_bits(2)) tick();   // random gaps
      end
      end_test();

      start_test("config");   // each write has to wait for the previous items
      for (int s = 0; s < 3; s++)
      begin
         write_cfg(sew_list[s]);
         for (int i = 0; i < 8; i++)
            send_req(make_req(op_list[draw_bits(5) % 17], 1'b1));
      end
      end_test();

      total = err_cnt + dut_i.u_assert.fail_cnt;
      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               n_tests, chk_cnt, err_cnt, dut_i.u_assert.fail_cnt);
      if (total == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: valu.f
+incdir+verilog
verilog/valu_pkg.sv
verilog/valu_csr.sv
verilog/valu_pipe_ctrl.sv
verilog/valu_lane.sv
verilog/valu_top.sv
verification/valu_assertions.sv
verification/valu_tb.sv

// File: Bender.yml
package:
  name: valu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/valu_pkg.sv
      - verilog/valu_csr.sv
      - verilog/valu_pipe_ctrl.sv
      - verilog/valu_lane.sv
      - verilog/valu_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verification/valu_assertions.sv
      - verification/valu_tb.sv
